// File: verilog/rv_isa_pkg.sv
// RV32 major opcodes, funct codes, SYSTEM immediates and the instruction word union
`default_nettype none

package rv_isa_pkg;

  // Major opcodes kept by this core
  localparam logic [6:0] op_lui      = 7'b0110111;
  localparam logic [6:0] op_auipc    = 7'b0010111;
  localparam logic [6:0] op_jal      = 7'b1101111;
  localparam logic [6:0] op_jalr     = 7'b1100111;
  localparam logic [6:0] op_branch   = 7'b1100011;
  localparam logic [6:0] op_load     = 7'b0000011;
  localparam logic [6:0] op_store    = 7'b0100011;
  localparam logic [6:0] op_imm      = 7'b0010011;
  localparam logic [6:0] op_op       = 7'b0110011;
  localparam logic [6:0] op_fence    = 7'b0001111;
  localparam logic [6:0] op_system   = 7'b1110011;
  localparam logic [6:0] op_load_fp  = 7'b0000111;  // FLW
  localparam logic [6:0] op_store_fp = 7'b0100111;  // FSW
  localparam logic [6:0] op_op_fp    = 7'b1010011;
  localparam logic [6:0] op_madd     = 7'b1000011;  // Fused multiply-add group
  localparam logic [6:0] op_msub     = 7'b1000111;
  localparam logic [6:0] op_nmsub    = 7'b1001011;
  localparam logic [6:0] op_nmadd    = 7'b1001111;

  localparam logic [2:0] funct3_priv   = 3'b000;     // ECALL, EBREAK, MRET
  localparam int         csr_imm_bit   = 2;          // funct3 bit picking uimm over rs1
  localparam logic [2:0] funct3_word   = 3'b010;     // 32-bit FP load/store width
  localparam logic [2:0] rm_dyn        = 3'b111;     // Rounding mode taken from fcsr
  localparam logic [6:0] funct7_muldiv = 7'b0000001;
  localparam logic [1:0] fmt_single    = 2'b00;

  // funct12 of the privileged SYSTEM words
  localparam logic [11:0] priv_ecall  = 12'h000;
  localparam logic [11:0] priv_ebreak = 12'h001;
  localparam logic [11:0] priv_mret   = 12'h302;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fields_t;

  // FP view, funct7 splits into funct5 and format, funct3 is rounding mode
  typedef struct packed {
    logic [4:0] rs3;
    logic [1:0] fmt;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] rm;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r4_fields_t;

  typedef union packed {
    r_fields_t  r_fields;
    r4_fields_t r4_fields;
  } inst_word_t;

endpackage

`default_nettype wire

// File: verilog/rv_ctrl_pkg.sv
// Control output encodings: ALU ops, write-back sources, immediate formats, FP ops, M ops
`default_nettype none

package rv_ctrl_pkg;

  localparam int alu_w  = 4;
  localparam int wb_w   = 3;
  localparam int imm_w  = 3;
  localparam int fpop_w = 5;
  localparam int mdop_w = 4;  // {1'b0, funct3} of the M instruction

  // Integer ALU operations
  localparam logic [alu_w-1:0] alu_add  = 4'd0;
  localparam logic [alu_w-1:0] alu_sub  = 4'd1;
  localparam logic [alu_w-1:0] alu_sll  = 4'd2;
  localparam logic [alu_w-1:0] alu_slt  = 4'd3;
  localparam logic [alu_w-1:0] alu_sltu = 4'd4;
  localparam logic [alu_w-1:0] alu_xor  = 4'd5;
  localparam logic [alu_w-1:0] alu_srl  = 4'd6;
  localparam logic [alu_w-1:0] alu_sra  = 4'd7;
  localparam logic [alu_w-1:0] alu_or   = 4'd8;
  localparam logic [alu_w-1:0] alu_and  = 4'd9;

  // Write-back sources, 5 is unused without atomics
  localparam logic [wb_w-1:0] wb_alu     = 3'd0;
  localparam logic [wb_w-1:0] wb_mem     = 3'd1;
  localparam logic [wb_w-1:0] wb_pc4     = 3'd2;
  localparam logic [wb_w-1:0] wb_csr     = 3'd3;
  localparam logic [wb_w-1:0] wb_mdu     = 3'd4;
  localparam logic [wb_w-1:0] wb_fpu_int = 3'd6;

  localparam logic [imm_w-1:0] imm_i = 3'd0;
  localparam logic [imm_w-1:0] imm_s = 3'd1;
  localparam logic [imm_w-1:0] imm_b = 3'd2;
  localparam logic [imm_w-1:0] imm_u = 3'd3;
  localparam logic [imm_w-1:0] imm_j = 3'd4;

  // FP unit operations
  localparam logic [fpop_w-1:0] fp_add    = 5'd0;
  localparam logic [fpop_w-1:0] fp_sub    = 5'd1;
  localparam logic [fpop_w-1:0] fp_mul    = 5'd2;
  localparam logic [fpop_w-1:0] fp_div    = 5'd3;
  localparam logic [fpop_w-1:0] fp_sqrt   = 5'd4;
  localparam logic [fpop_w-1:0] fp_sgnj   = 5'd5;
  localparam logic [fpop_w-1:0] fp_sgnjn  = 5'd6;
  localparam logic [fpop_w-1:0] fp_sgnjx  = 5'd7;
  localparam logic [fpop_w-1:0] fp_min    = 5'd8;
  localparam logic [fpop_w-1:0] fp_max    = 5'd9;
  localparam logic [fpop_w-1:0] fp_cvt    = 5'd10;
  localparam logic [fpop_w-1:0] fp_cmp    = 5'd11;
  localparam logic [fpop_w-1:0] fp_class  = 5'd12;
  localparam logic [fpop_w-1:0] fp_fma    = 5'd13;
  localparam logic [fpop_w-1:0] fp_fmsub  = 5'd14;
  localparam logic [fpop_w-1:0] fp_fnmsub = 5'd15;
  localparam logic [fpop_w-1:0] fp_fnmadd = 5'd16;
  localparam logic [fpop_w-1:0] fp_mv_xw  = 5'd17;  // FP bits to integer reg
  localparam logic [fpop_w-1:0] fp_mv_wx  = 5'd18;

endpackage

`default_nettype wire

// File: verilog/inst_decoder.sv
// inst_decoder: instruction field view and instruction class flags
`timescale 1ns/1ns
`default_nettype none

module inst_decoder
  import rv_isa_pkg::*;
#(
  parameter bit has_mul = 1'b1,
  parameter bit has_fp  = 1'b1
) (
  input  logic [31:0] instr,
  output inst_word_t  inst,
  output logic        is_csr,
  output logic        is_ecall,
  output logic        is_ebreak,
  output logic        is_mret,
  output logic        is_mul_div,
  output logic        is_fp
);

  logic [11:0] funct12;
  logic        sys_op;
  logic        priv_op;
  logic        fp_opcode;

  assign inst    = instr;
  assign funct12 = {inst.r_fields.funct7, inst.r_fields.rs2};
  assign sys_op  = (inst.r_fields.opcode == op_system);

  // Privileged forms need rd and rs1 both x0
  assign priv_op = sys_op && (inst.r_fields.funct3 == funct3_priv)
                   && (inst.r_fields.rd == 5'd0) && (inst.r_fields.rs1 == 5'd0);

  // funct3 100 is reserved, 000 is the privileged group
  assign is_csr    = sys_op && (inst.r_fields.funct3[1:0] != 2'b00);
  assign is_ecall  = priv_op && (funct12 == priv_ecall);
  assign is_ebreak = priv_op && (funct12 == priv_ebreak);
  assign is_mret   = priv_op && (funct12 == priv_mret);

  assign is_mul_div = has_mul && (inst.r_fields.opcode == op_op)
                      && (inst.r_fields.funct7 == funct7_muldiv);

  // Any of the seven F opcodes
  assign fp_opcode = inst.r_fields.opcode inside {op_load_fp, op_store_fp, op_op_fp,
                                                   op_madd, op_msub, op_nmsub, op_nmadd};
  assign is_fp     = has_fp && fp_opcode;  // Without an FPU these fall to illegal

endmodule

`default_nettype wire

// File: verilog/int_control.sv
// int_control: base integer, M-extension and SYSTEM control generation
`timescale 1ns/1ns
`default_nettype none

module int_control
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
(
  input  inst_word_t        inst,
  input  logic              is_csr,
  input  logic              is_ecall,
  input  logic              is_ebreak,
  input  logic              is_mret,
  input  logic              is_mul_div,
  input  logic              is_fp,
  output logic              reg_write,
  output logic              mem_read,
  output logic              mem_write,
  output logic              branch,
  output logic              jump,
  output logic [alu_w-1:0]  alu_control,
  output logic              alu_src,     // 1 selects the immediate
  output logic [wb_w-1:0]   wb_sel,
  output logic [imm_w-1:0]  imm_sel,
  output logic              csr_we,
  output logic              csr_src,     // 1 selects uimm
  output logic              mul_div_en,
  output logic [mdop_w-1:0] mul_div_op,
  output logic              int_illegal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = inst.r_fields.opcode;
  assign funct3 = inst.r_fields.funct3;
  assign funct7 = inst.r_fields.funct7;

  // ALU op from funct3, bit 30 picks SUB (R-type only) and SRA
  function automatic logic [alu_w-1:0] alu_op(
    input logic [2:0] f3,
    input logic [6:0] f7,
    input logic       reg_op
  );
    case (f3)
      3'b000:  alu_op = (reg_op && f7[5]) ? alu_sub : alu_add;
      3'b001:  alu_op = alu_sll;
      3'b010:  alu_op = alu_slt;
      3'b011:  alu_op = alu_sltu;
      3'b100:  alu_op = alu_xor;
      3'b101:  alu_op = f7[5] ? alu_sra : alu_srl;
      3'b110:  alu_op = alu_or;
      default: alu_op = alu_and;
    endcase
  endfunction

  always_comb begin
    reg_write   = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    branch      = 1'b0;
    jump        = 1'b0;
    alu_control = alu_add;
    alu_src     = 1'b0;
    wb_sel      = wb_alu;
    imm_sel     = imm_i;
    csr_we      = 1'b0;
    csr_src     = 1'b0;
    mul_div_en  = 1'b0;
    mul_div_op  = '0;
    int_illegal = 1'b0;
    case (opcode)
      op_lui, op_auipc: begin  // ALU adds U-immediate to zero or PC
        reg_write = 1'b1;
        alu_src   = 1'b1;
        imm_sel   = imm_u;
      end
      op_jal: begin
        reg_write = 1'b1;
        jump      = 1'b1;
        wb_sel    = wb_pc4;  // Link address
        imm_sel   = imm_j;
      end
      op_jalr: begin  // Target is rs1 + imm
        reg_write = 1'b1;
        jump      = 1'b1;
        alu_src   = 1'b1;
        wb_sel    = wb_pc4;
      end
      op_branch: begin
        branch      = 1'b1;
        alu_control = alu_sub;  // Compare by subtraction
        imm_sel     = imm_b;
      end
      op_load: begin
        reg_write = 1'b1;
        mem_read  = 1'b1;
        alu_src   = 1'b1;  // Address rs1 + offset
        wb_sel    = wb_mem;
      end
      op_store: begin
        mem_write = 1'b1;
        alu_src   = 1'b1;
        imm_sel   = imm_s;
      end
      op_imm: begin
        reg_write   = 1'b1;
        alu_src     = 1'b1;
        alu_control = alu_op(funct3, funct7, 1'b0);
      end
      op_op: begin
        if (is_mul_div) begin
          reg_write  = 1'b1;
          mul_div_en = 1'b1;
          mul_div_op = {1'b0, funct3};  // MUL..REMU
          wb_sel     = wb_mdu;
        end else if (funct7 == funct7_muldiv) begin
          int_illegal = 1'b1;  // M encoding, no multiplier built
        end else begin
          reg_write   = 1'b1;
          alu_control = alu_op(funct3, funct7, 1'b1);
        end
      end
      op_fence: ;  // In-order core, nothing to order
      op_system: begin
        if (is_csr) begin
          reg_write = 1'b1;  // Old CSR value to rd
          wb_sel    = wb_csr;
          csr_we    = 1'b1;
          csr_src   = funct3[csr_imm_bit];
        end else if (is_mret) begin
          jump = 1'b1;  // Return through mepc
        end else if (!(is_ecall || is_ebreak)) begin
          int_illegal = 1'b1;  // ECALL/EBREAK raise their trap later
        end
      end
      default: int_illegal = !is_fp;  // FP opcodes belong to fp_control
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/fp_control.sv
// fp_control: single-precision F-extension control generation
`timescale 1ns/1ns
`default_nettype none

module fp_control
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
(
  input  inst_word_t        inst,
  input  logic              is_fp,
  output logic              fp_reg_write,
  output logic              int_reg_write_fp,  // Result to an x register
  output logic              fp_mem_op,
  output logic              fp_alu_en,
  output logic [fpop_w-1:0] fp_alu_op,
  output logic              fp_use_dynamic_rm,
  output logic              mem_read,
  output logic              mem_write,
  output logic              alu_src,
  output logic [imm_w-1:0]  imm_sel,
  output logic [wb_w-1:0]   wb_sel,
  output logic              fp_illegal
);

  logic [4:0] funct5;
  logic       single;
  logic       dyn_rm;

  assign funct5 = inst.r4_fields.rs3;
  assign single = (inst.r4_fields.fmt == fmt_single);
  assign dyn_rm = (inst.r4_fields.rm == rm_dyn);

  always_comb begin
    fp_reg_write      = 1'b0;
    int_reg_write_fp  = 1'b0;
    fp_mem_op         = 1'b0;
    fp_alu_en         = 1'b0;
    fp_alu_op         = fp_add;
    fp_use_dynamic_rm = 1'b0;
    mem_read          = 1'b0;
    mem_write         = 1'b0;
    alu_src           = 1'b0;
    imm_sel           = imm_i;
    wb_sel            = wb_alu;
    fp_illegal        = 1'b0;
    if (is_fp) begin
      case (inst.r4_fields.opcode)
        op_load_fp, op_store_fp: begin
          if (inst.r4_fields.rm == funct3_word) begin  // FLW or FSW
            fp_mem_op    = 1'b1;
            alu_src      = 1'b1;
            fp_reg_write = !inst.r4_fields.opcode[5];  // Bit 5 set for store
            mem_read     = !inst.r4_fields.opcode[5];
            mem_write    = inst.r4_fields.opcode[5];
            imm_sel      = inst.r4_fields.opcode[5] ? imm_s : imm_i;
            wb_sel       = inst.r4_fields.opcode[5] ? wb_alu : wb_mem;
          end else begin
            fp_illegal = 1'b1;  // FLD/FSD and odd widths
          end
        end
        op_madd, op_msub, op_nmsub, op_nmadd: begin
          if (single) begin
            fp_reg_write      = 1'b1;
            fp_alu_en         = 1'b1;
            fp_use_dynamic_rm = dyn_rm;
            case (inst.r4_fields.opcode)
              op_madd:  fp_alu_op = fp_fma;
              op_msub:  fp_alu_op = fp_fmsub;
              op_nmsub: fp_alu_op = fp_fnmsub;
              default:  fp_alu_op = fp_fnmadd;
            endcase
          end else begin
            fp_illegal = 1'b1;
          end
        end
        op_op_fp: begin
          if (!single) begin
            fp_illegal = 1'b1;  // No double precision
          end else begin
            case (funct5)
              5'b00000, 5'b00001, 5'b00010, 5'b00011, 5'b01011: begin
                fp_reg_write      = 1'b1;
                fp_alu_en         = 1'b1;
                fp_use_dynamic_rm = dyn_rm;
                case (funct5)
                  5'b00000: fp_alu_op = fp_add;
                  5'b00001: fp_alu_op = fp_sub;
                  5'b00010: fp_alu_op = fp_mul;
                  5'b00011: fp_alu_op = fp_div;
                  default:  fp_alu_op = fp_sqrt;
                endcase
              end
              5'b00100: begin  // Sign injection, variant in funct3
                case (inst.r4_fields.rm)
                  3'b000:  fp_alu_op = fp_sgnj;
                  3'b001:  fp_alu_op = fp_sgnjn;
                  3'b010:  fp_alu_op = fp_sgnjx;
                  default: fp_illegal = 1'b1;
                endcase
                fp_reg_write = !fp_illegal;
                fp_alu_en    = !fp_illegal;
              end
              5'b00101: begin
                fp_reg_write = 1'b1;
                fp_alu_en    = 1'b1;
                fp_alu_op    = inst.r4_fields.rm[0] ? fp_max : fp_min;
              end
              5'b11000, 5'b11010: begin  // FCVT.W[U].S, bit 1 turns it to FCVT.S.W[U]
                int_reg_write_fp  = !funct5[1];
                fp_reg_write      = funct5[1];
                wb_sel            = funct5[1] ? wb_alu : wb_fpu_int;
                fp_alu_en         = 1'b1;
                fp_alu_op         = fp_cvt;
                fp_use_dynamic_rm = dyn_rm;
              end
              5'b10100: begin  // FEQ, FLT, FLE
                int_reg_write_fp = 1'b1;
                fp_alu_en        = 1'b1;
                fp_alu_op        = fp_cmp;
                wb_sel           = wb_fpu_int;
              end
              5'b11100: begin
                int_reg_write_fp = 1'b1;
                wb_sel           = wb_fpu_int;
                case (inst.r4_fields.rm)
                  3'b000: fp_alu_op = fp_mv_xw;  // Raw move, ALU idle
                  3'b001: begin
                    fp_alu_en = 1'b1;
                    fp_alu_op = fp_class;
                  end
                  default: fp_illegal = 1'b1;
                endcase
              end
              5'b11110: begin
                fp_reg_write = 1'b1;
                fp_alu_op    = fp_mv_wx;
              end
              default: fp_illegal = 1'b1;
            endcase
          end
        end
        default: fp_illegal = 1'b1;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/ctrl_register.sv
// ctrl_register: int/FP control merge, illegal flag and decode/execute pipeline register
`timescale 1ns/1ns
`default_nettype none

module ctrl_register
  import rv_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              instr_valid,
  input  logic              is_fp,
  input  logic              dec_reg_write,
  input  logic              dec_branch,
  input  logic              dec_jump,
  input  logic [alu_w-1:0]  dec_alu_control,
  input  logic              dec_csr_we,
  input  logic              dec_csr_src,
  input  logic              dec_mul_div_en,
  input  logic [mdop_w-1:0] dec_mul_div_op,
  input  logic              int_mem_read,
  input  logic              int_mem_write,
  input  logic              int_alu_src,
  input  logic [wb_w-1:0]   int_wb_sel,
  input  logic [imm_w-1:0]  int_imm_sel,
  input  logic              int_illegal,
  input  logic              dec_fp_reg_write,
  input  logic              dec_int_reg_write_fp,
  input  logic              dec_fp_mem_op,
  input  logic              dec_fp_alu_en,
  input  logic [fpop_w-1:0] dec_fp_alu_op,
  input  logic              dec_fp_use_dynamic_rm,
  input  logic              fp_mem_read,
  input  logic              fp_mem_write,
  input  logic              fp_alu_src,
  input  logic [wb_w-1:0]   fp_wb_sel,
  input  logic [imm_w-1:0]  fp_imm_sel,
  input  logic              fp_illegal,
  output logic              reg_write,
  output logic              mem_read,
  output logic              mem_write,
  output logic              branch,
  output logic              jump,
  output logic [alu_w-1:0]  alu_control,
  output logic              alu_src,
  output logic [wb_w-1:0]   wb_sel,
  output logic [imm_w-1:0]  imm_sel,
  output logic              csr_we,
  output logic              csr_src,
  output logic              mul_div_en,
  output logic [mdop_w-1:0] mul_div_op,
  output logic              fp_reg_write,
  output logic              int_reg_write_fp,
  output logic              fp_mem_op,
  output logic              fp_alu_en,
  output logic [fpop_w-1:0] fp_alu_op,
  output logic              fp_use_dynamic_rm,
  output logic              illegal_inst,
  output logic              ctrl_valid
);

  // 16 single-bit controls plus the encoded fields
  localparam int ctrl_bits = 16 + alu_w + wb_w + imm_w + mdop_w + fpop_w;

  logic [ctrl_bits-1:0] next_ctrl;
  logic [ctrl_bits-1:0] ctrl_q;

  // Memory, operand and write-back fields come from the FP set on FP opcodes
  assign next_ctrl = {
    dec_reg_write,
    is_fp ? fp_mem_read  : int_mem_read,
    is_fp ? fp_mem_write : int_mem_write,
    dec_branch,
    dec_jump,
    dec_alu_control,
    is_fp ? fp_alu_src   : int_alu_src,
    is_fp ? fp_wb_sel    : int_wb_sel,
    is_fp ? fp_imm_sel   : int_imm_sel,
    dec_csr_we,
    dec_csr_src,
    dec_mul_div_en,
    dec_mul_div_op,
    dec_fp_reg_write,
    dec_int_reg_write_fp,
    dec_fp_mem_op,
    dec_fp_alu_en,
    dec_fp_alu_op,
    dec_fp_use_dynamic_rm,
    int_illegal | fp_illegal,
    1'b1                         // Becomes ctrl_valid
  };

  always_ff @(posedge clk) begin
    if (reset || !instr_valid) begin
      ctrl_q <= '0;  // Bubble, nothing issues
    end else begin
      ctrl_q <= next_ctrl;
    end
  end

  assign {reg_write, mem_read, mem_write, branch, jump, alu_control, alu_src, wb_sel,
          imm_sel, csr_we, csr_src, mul_div_en, mul_div_op, fp_reg_write,
          int_reg_write_fp, fp_mem_op, fp_alu_en, fp_alu_op, fp_use_dynamic_rm,
          illegal_inst, ctrl_valid} = ctrl_q;

endmodule

`default_nettype wire

// File: verilog/control_unit.sv
// control_unit: decode stage top, decoder, control generators and pipeline register
`timescale 1ns/1ns
`default_nettype none

module control_unit
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;
#(
  parameter bit has_mul = 1'b1,
  parameter bit has_fp  = 1'b1
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [31:0]       instr,
  input  logic              instr_valid,  // One cycle per instruction
  output logic              reg_write,
  output logic              mem_read,
  output logic              mem_write,
  output logic              branch,
  output logic              jump,
  output logic [alu_w-1:0]  alu_control,
  output logic              alu_src,
  output logic [wb_w-1:0]   wb_sel,
  output logic [imm_w-1:0]  imm_sel,
  output logic              csr_we,
  output logic              csr_src,
  output logic              mul_div_en,
  output logic [mdop_w-1:0] mul_div_op,
  output logic              fp_reg_write,
  output logic              int_reg_write_fp,
  output logic              fp_mem_op,
  output logic              fp_alu_en,
  output logic [fpop_w-1:0] fp_alu_op,
  output logic              fp_use_dynamic_rm,
  output logic              illegal_inst,
  output logic              ctrl_valid
);

  inst_word_t        inst;
  logic              is_csr;
  logic              is_ecall;
  logic              is_ebreak;
  logic              is_mret;
  logic              is_mul_div;
  logic              is_fp;
  logic              dec_reg_write;  // Integer set, before the register
  logic              dec_branch;
  logic              dec_jump;
  logic [alu_w-1:0]  dec_alu_control;
  logic              dec_csr_we;
  logic              dec_csr_src;
  logic              dec_mul_div_en;
  logic [mdop_w-1:0] dec_mul_div_op;
  logic              int_mem_read;
  logic              int_mem_write;
  logic              int_alu_src;
  logic [wb_w-1:0]   int_wb_sel;
  logic [imm_w-1:0]  int_imm_sel;
  logic              int_illegal;
  logic              dec_fp_reg_write;  // FP set
  logic              dec_int_reg_write_fp;
  logic              dec_fp_mem_op;
  logic              dec_fp_alu_en;
  logic [fpop_w-1:0] dec_fp_alu_op;
  logic              dec_fp_use_dynamic_rm;
  logic              fp_mem_read;
  logic              fp_mem_write;
  logic              fp_alu_src;
  logic [wb_w-1:0]   fp_wb_sel;
  logic [imm_w-1:0]  fp_imm_sel;
  logic              fp_illegal;

  inst_decoder #(.has_mul(has_mul), .has_fp(has_fp)) u_dec (.*);

  int_control u_int (
    .inst, .is_csr, .is_ecall, .is_ebreak, .is_mret, .is_mul_div, .is_fp,
    .reg_write(dec_reg_write), .mem_read(int_mem_read), .mem_write(int_mem_write),
    .branch(dec_branch), .jump(dec_jump), .alu_control(dec_alu_control),
    .alu_src(int_alu_src), .wb_sel(int_wb_sel), .imm_sel(int_imm_sel),
    .csr_we(dec_csr_we), .csr_src(dec_csr_src), .mul_div_en(dec_mul_div_en),
    .mul_div_op(dec_mul_div_op), .int_illegal
  );

  fp_control u_fp (
    .inst, .is_fp,
    .fp_reg_write(dec_fp_reg_write), .int_reg_write_fp(dec_int_reg_write_fp),
    .fp_mem_op(dec_fp_mem_op), .fp_alu_en(dec_fp_alu_en), .fp_alu_op(dec_fp_alu_op),
    .fp_use_dynamic_rm(dec_fp_use_dynamic_rm), .mem_read(fp_mem_read),
    .mem_write(fp_mem_write), .alu_src(fp_alu_src), .imm_sel(fp_imm_sel),
    .wb_sel(fp_wb_sel), .fp_illegal
  );

  // Names line up one to one with the register ports
  ctrl_register u_reg (.*);

endmodule

`default_nettype wire

// File: test/clock_gen.sv
// clock_gen: free-running testbench clock and synchronous reset pulse
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
  parameter int period       = 8,
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;  // Drops just after the last reset edge
  end

endmodule

`default_nettype wire

// File: test/control_unit_tb.sv
// Vector-driven testbench and watchdog for the decode stage control unit
`timescale 1ns/1ns
`default_nettype none

module control_unit_tb
  import rv_ctrl_pkg::*;
();

  localparam int num_tests  = 33;  // Lines in the vector file
  localparam int vec_bits   = 35;
  localparam int clk_period = 8;
  localparam int max_cycles = num_tests * 5 + 20;

  logic              clk;
  logic              reset;
  logic [31:0]       instr;
  logic              instr_valid;
  logic              reg_write;
  logic              mem_read;
  logic              mem_write;
  logic              branch;
  logic              jump;
  logic [alu_w-1:0]  alu_control;
  logic              alu_src;
  logic [wb_w-1:0]   wb_sel;
  logic [imm_w-1:0]  imm_sel;
  logic              csr_we;
  logic              csr_src;
  logic              mul_div_en;
  logic [mdop_w-1:0] mul_div_op;
  logic              fp_reg_write;
  logic              int_reg_write_fp;
  logic              fp_mem_op;
  logic              fp_alu_en;
  logic [fpop_w-1:0] fp_alu_op;
  logic              fp_use_dynamic_rm;
  logic              illegal_inst;
  logic              ctrl_valid;

  logic [35:0]         vectors [0:2*num_tests-1];  // Instruction at even index, controls at odd
  logic [vec_bits-1:0] expected;                   // Due at the next falling edge
  logic [31:0]         rng;
  int                  errors;

  clock_gen #(.period(clk_period), .reset_cycles(8)) u_clk (.clk(clk), .reset(reset));

  control_unit #(.has_mul(1'b1), .has_fp(1'b1)) UUT (
    .clk(clk), .reset(reset), .instr(instr), .instr_valid(instr_valid),
    .reg_write(reg_write), .mem_read(mem_read), .mem_write(mem_write),
    .branch(branch), .jump(jump), .alu_control(alu_control), .alu_src(alu_src),
    .wb_sel(wb_sel), .imm_sel(imm_sel), .csr_we(csr_we), .csr_src(csr_src),
    .mul_div_en(mul_div_en), .mul_div_op(mul_div_op), .fp_reg_write(fp_reg_write),
    .int_reg_write_fp(int_reg_write_fp), .fp_mem_op(fp_mem_op), .fp_alu_en(fp_alu_en),
    .fp_alu_op(fp_alu_op), .fp_use_dynamic_rm(fp_use_dynamic_rm),
    .illegal_inst(illegal_inst), .ctrl_valid(ctrl_valid)
  );

  // Classic 32-bit LCG step
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    lcg_next = state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      errors++;
      $display("error %s got %h expected %h at %0t ns", name, got, want, $time);
    end
  endtask

  // Field split follows the port order of the top level
  task automatic check_outputs(input logic [vec_bits-1:0] want);
    check_value("reg_write", 32'(reg_write), 32'(want[34]));
    check_value("mem_read", 32'(mem_read), 32'(want[33]));
    check_value("mem_write", 32'(mem_write), 32'(want[32]));
    check_value("branch", 32'(branch), 32'(want[31]));
    check_value("jump", 32'(jump), 32'(want[30]));
    check_value("alu_control", 32'(alu_control), 32'(want[29:26]));
    check_value("alu_src", 32'(alu_src), 32'(want[25]));
    check_value("wb_sel", 32'(wb_sel), 32'(want[24:22]));
    check_value("imm_sel", 32'(imm_sel), 32'(want[21:19]));
    check_value("csr_we", 32'(csr_we), 32'(want[18]));
    check_value("csr_src", 32'(csr_src), 32'(want[17]));
    check_value("mul_div_en", 32'(mul_div_en), 32'(want[16]));
    check_value("mul_div_op", 32'(mul_div_op), 32'(want[15:12]));
    check_value("fp_reg_write", 32'(fp_reg_write), 32'(want[11]));
    check_value("int_reg_write_fp", 32'(int_reg_write_fp), 32'(want[10]));
    check_value("fp_mem_op", 32'(fp_mem_op), 32'(want[9]));
    check_value("fp_alu_en", 32'(fp_alu_en), 32'(want[8]));
    check_value("fp_alu_op", 32'(fp_alu_op), 32'(want[7:3]));
    check_value("fp_use_dynamic_rm", 32'(fp_use_dynamic_rm), 32'(want[2]));
    check_value("illegal_inst", 32'(illegal_inst), 32'(want[1]));
    check_value("ctrl_valid", 32'(ctrl_valid), 32'(want[0]));
  endtask

  // Checks the previous result and drives the next input on the falling edge
  task automatic issue_cycle(input logic valid, input logic [31:0] word,
                             input logic [vec_bits-1:0] next_want);
    @(negedge clk);
    check_outputs(expected);
    instr       = word;
    instr_valid = valid;
    expected    = next_want;
  endtask

  task automatic run_pass(input logic with_gaps);
    int gaps;
    for (int i = 0; i < num_tests; i++) begin
      gaps = 0;
      if (with_gaps) begin
        rng  = lcg_next(rng);
        gaps = int'(rng[17:16]);  // Zero to three idle cycles
      end
      for (int g = 0; g < gaps; g++) begin
        rng = lcg_next(rng);
        issue_cycle(1'b0, rng, '0);  // Random junk word with valid low gives a bubble
      end
      issue_cycle(1'b1, vectors[2*i][31:0], vectors[2*i+1][vec_bits-1:0]);
    end
  endtask

  initial begin
    errors      = 0;
    rng         = 32'd94;
    expected    = '0;
    $readmemh("test/control_tests.hex", vectors);
    instr       = vectors[0][31:0];  // Held valid through reset and never loaded
    instr_valid = 1'b1;
    for (int i = 0; i < num_tests; i++) begin
      if (vectors[2*i+1][0] !== 1'b1) begin  // Every real entry expects ctrl_valid
        errors++;
        $display("Test vector %0d is missing from the vector file", i);
      end
    end
    @(negedge reset);
    @(negedge clk);
    check_outputs('0);  // Cleared by reset
    instr_valid = 1'b0;
    run_pass(1'b1);
    run_pass(1'b0);     // One instruction per cycle with no gaps
    issue_cycle(1'b0, '0, '0);
    issue_cycle(1'b0, '0, '0);
    $display("%0d errors over %0d test vectors", errors, num_tests);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog sized from the vector count
  initial begin
    repeat (max_cycles) @(posedge clk);
    $display("Timeout, the test sequence did not finish within %0d clock periods",
             max_cycles);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_ctrl.f
verilog/rv_isa_pkg.sv
verilog/rv_ctrl_pkg.sv
verilog/inst_decoder.sv
verilog/int_control.sv
verilog/fp_control.sv
verilog/ctrl_register.sv
verilog/control_unit.sv
test/clock_gen.sv
test/control_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the control unit testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -f rv_ctrl.f \
  --top-module control_unit_tb -o control_unit_sim

./obj_dir/control_unit_sim > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
exit 0

// File: test/control_tests.hex
// Columns: instruction word, expected controls {reg_write .. ctrl_valid} in port order
// Control word is 35 bits, zero padded to 9 hex digits
123450B7 402180001  // LUI x1, 0x12345
100000EF 440A00001  // JAL x1, +0x100
000280E7 442800001  // JALR x1, 0(x5)
00208463 084100001  // BEQ x1, x2, +8
0040A183 602400001  // LW x3, 4(x1)
0030A423 102080001  // SW x3, 8(x1)
FFF10093 402000001  // ADDI x1, x2, -1, bit 30 set but still add
40315093 41E000001  // SRAI x1, x2, 3
00F2F213 426000001  // ANDI x4, x5, 0xf
402081B3 404000001  // SUB x3, x1, x2
4020D1B3 41C000001  // SRA x3, x1, x2
007332B3 410000001  // SLTU x5, x6, x7
022081B3 401010001  // MUL x3, x1, x2
0220D1B3 401015001  // DIVU x3, x1, x2
300110F3 400C40001  // CSRRW x1, mstatus, x2
3002E0F3 400C60001  // CSRRSI x1, mstatus, 5
00000073 000000001  // ECALL
00100073 000000001  // EBREAK
30200073 040000001  // MRET
10500073 000000003  // WFI, not supported here
0000007F 000000003  // Unknown opcode
0FF0000F 000000001  // FENCE
00412087 202400A01  // FLW f1, 4(x2)
0030A427 102080201  // FSW f3, 8(x1)
003170D3 000000905  // FADD.S dynamic rounding
103100D3 000000911  // FMUL.S rne
203130D3 000000003  // FSGNJ funct3 3, reserved
203110D3 000000931  // FSGNJN.S
C00170D3 001800555  // FCVT.W.S x1, f2, dyn
A03120D3 001800559  // FEQ.S x1, f2, f3
203100C3 000000969  // FMADD.S f1, f2, f3, f4
023170D3 000000003  // FADD.D, no double support
E00100D3 001800489  // FMV.X.W x1, f2
